/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_census
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Done: errors found
PASS_MSG = Done: no errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without finishing"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

/* census/census_scan.sv */
`timescale 1ns/1ps

module census_scan import census_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_req,
    input  logic [cnt_width-1:0]   qry_cnt,
    output logic                   busy,
    output logic [coord_width-1:0] qry_row,
    output logic [coord_width-1:0] qry_col,
    output logic                   wr_en,
    output logic [coord_width-1:0] wr_row,
    output logic [coord_width-1:0] wr_col,
    output logic [cnt_width-1:0]   wr_cnt,
    output logic                   scan_done,
    output logic [total_width-1:0] total
);

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_init = 3'd1;
    localparam logic [2:0] st_addr = 3'd2;  // drive query address
    localparam logic [2:0] st_wait = 3'd3;  // storage may answer a cycle late
    localparam logic [2:0] st_read = 3'd4;  // sample, cache, accumulate

    logic [2:0]             state;
    logic [coord_width-1:0] r_idx;
    logic [coord_width-1:0] c_idx;

    // cache write happens on the edge leaving the read state
    assign wr_en  = (state == st_read);
    assign wr_row = r_idx;
    assign wr_col = c_idx;
    assign wr_cnt = qry_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            busy      <= 1'b0;
            scan_done <= 1'b0;
            total     <= '0;
            qry_row   <= coord_width'(1);
            qry_col   <= coord_width'(1);
            r_idx     <= coord_width'(1);
            c_idx     <= coord_width'(1);
        end else begin
            scan_done <= 1'b0;  // one-cycle pulse
            case (state)
                st_idle: begin
                    busy <= start_req;  // top only passes starts while idle
                    if (start_req) begin
                        state <= st_init;
                    end
                end
                st_init: begin
                    r_idx <= coord_width'(1);
                    c_idx <= coord_width'(1);
                    total <= '0;
                    state <= st_addr;
                end
                st_addr: begin
                    qry_row <= r_idx;
                    qry_col <= c_idx;
                    state   <= st_wait;
                end
                st_wait: state <= st_read;
                st_read: begin
                    total <= total + total_width'(qry_cnt);
                    // column first, then row
                    if (c_idx < max_size) begin
                        c_idx <= c_idx + 3'd1;
                        state <= st_addr;
                    end else if (r_idx < max_size) begin
                        r_idx <= r_idx + 3'd1;
                        c_idx <= coord_width'(1);
                        state <= st_addr;
                    end else begin
                        scan_done <= 1'b1;  // busy stays up this cycle
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // write only after the address has been held through the wait cycle
    a_wr_after_wait: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> $past(state) == st_wait && qry_row == wr_row && qry_col == wr_col);

    a_qry_range: assert property (@(posedge clk) disable iff (!rst_n)
        qry_row >= 1 && qry_row <= max_size && qry_col >= 1 && qry_col <= max_size);

endmodule

/* census/matrix_census_report.sv */
`timescale 1ns/1ps

module matrix_census_report import census_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_req,
    input  logic                   tx_busy,
    input  logic [cnt_width-1:0]   qry_cnt,
    output logic                   busy,
    output logic                   tx_start,
    output logic [7:0]             tx_data,
    output logic [coord_width-1:0] qry_row,
    output logic [coord_width-1:0] qry_col
);

    logic                   scan_busy;
    logic                   rpt_busy;
    logic                   start_go;
    logic                   wr_en;
    logic [coord_width-1:0] wr_row;
    logic [coord_width-1:0] wr_col;
    logic [cnt_width-1:0]   wr_cnt;
    logic                   scan_done;
    logic [total_width-1:0] total;
    logic [coord_width-1:0] rd_row;
    logic [coord_width-1:0] rd_col;
    logic [cnt_width-1:0]   rd_cnt;

    // scanner holds busy through scan_done, writer picks up the next cycle
    assign busy     = scan_busy | rpt_busy;
    assign start_go = start_req & ~busy;  // starts while busy are dropped

    census_scan u_scan (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_req (start_go),
        .qry_cnt   (qry_cnt),
        .busy      (scan_busy),
        .qry_row   (qry_row),
        .qry_col   (qry_col),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_col    (wr_col),
        .wr_cnt    (wr_cnt),
        .scan_done (scan_done),
        .total     (total)
    );

    count_cache u_cache (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .wr_row (wr_row),
        .wr_col (wr_col),
        .wr_cnt (wr_cnt),
        .rd_row (rd_row),
        .rd_col (rd_col),
        .rd_cnt (rd_cnt)
    );

    report_writer u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_done (scan_done),
        .total     (total),
        .rd_cnt    (rd_cnt),
        .tx_busy   (tx_busy),
        .busy      (rpt_busy),
        .rd_row    (rd_row),
        .rd_col    (rd_col),
        .tx_start  (tx_start),
        .tx_data   (tx_data)
    );

endmodule

/* census/report_writer.sv */
`timescale 1ns/1ps

module report_writer import census_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   scan_done,
    input  logic [total_width-1:0] total,
    input  logic [cnt_width-1:0]   rd_cnt,
    input  logic                   tx_busy,
    output logic                   busy,
    output logic [coord_width-1:0] rd_row,
    output logic [coord_width-1:0] rd_col,
    output logic                   tx_start,
    output logic [7:0]             tx_data
);

    // formatting states
    localparam logic [4:0] st_idle     = 5'd0;
    localparam logic [4:0] st_tot_hi   = 5'd1;
    localparam logic [4:0] st_tot_lo   = 5'd2;
    localparam logic [4:0] st_tot_sp   = 5'd3;
    localparam logic [4:0] st_chk      = 5'd4;
    localparam logic [4:0] st_row      = 5'd5;
    localparam logic [4:0] st_star1    = 5'd6;
    localparam logic [4:0] st_col      = 5'd7;
    localparam logic [4:0] st_star2    = 5'd8;
    localparam logic [4:0] st_cnt      = 5'd9;
    localparam logic [4:0] st_sp       = 5'd10;
    localparam logic [4:0] st_next     = 5'd11;
    localparam logic [4:0] st_finish   = 5'd12;  // return target for the last byte
    // send subroutine
    localparam logic [4:0] st_tx_start = 5'd16;
    localparam logic [4:0] st_tx_hi    = 5'd17;  // wait for tx_busy high
    localparam logic [4:0] st_tx_lo    = 5'd18;  // wait for tx_busy low
    localparam logic [4:0] st_tx_rec   = 5'd19;  // tx_start low for one cycle

    logic [4:0]             state;
    logic [4:0]             ret_state;
    logic [total_width-1:0] tot_q;
    logic [total_width-1:0] rem;  // count still to be listed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            ret_state <= st_idle;
            busy      <= 1'b0;
            tx_start  <= 1'b0;
            tx_data   <= '0;
            tot_q     <= '0;
            rem       <= '0;
            rd_row    <= coord_width'(1);
            rd_col    <= coord_width'(1);
        end else begin
            case (state)
                st_idle: begin
                    if (scan_done) begin
                        busy  <= 1'b1;
                        tot_q <= total;
                        rem   <= total;
                        state <= st_tot_hi;
                    end
                end

                // ========================================
                // total, then a space
                // ========================================
                st_tot_hi: begin
                    if (tot_q >= 10) begin
                        tx_data   <= ascii_zero + 8'(tot_q / 10);
                        ret_state <= st_tot_lo;
                        state     <= st_tx_start;
                    end else begin
                        state <= st_tot_lo;  // single digit
                    end
                end
                st_tot_lo: begin
                    tx_data   <= ascii_zero + 8'(tot_q % 10);
                    ret_state <= st_tot_sp;
                    state     <= st_tx_start;
                end
                st_tot_sp: begin
                    tx_data   <= ascii_space;
                    ret_state <= (tot_q == 0) ? st_finish : st_chk;
                    state     <= st_tx_start;
                    rd_row    <= coord_width'(1);
                    rd_col    <= coord_width'(1);
                end

                // ========================================
                // row*col*count for each nonzero size
                // ========================================
                st_chk: state <= (rd_cnt != 0) ? st_row : st_next;
                st_row: begin
                    tx_data   <= ascii_zero + 8'(rd_row);
                    ret_state <= st_star1;
                    state     <= st_tx_start;
                end
                st_star1: begin
                    tx_data   <= ascii_star;
                    ret_state <= st_col;
                    state     <= st_tx_start;
                end
                st_col: begin
                    tx_data   <= ascii_zero + 8'(rd_col);
                    ret_state <= st_star2;
                    state     <= st_tx_start;
                end
                st_star2: begin
                    tx_data   <= ascii_star;
                    ret_state <= st_cnt;
                    state     <= st_tx_start;
                end
                st_cnt: begin
                    tx_data   <= ascii_zero + 8'(rd_cnt);  // count below 10
                    rem       <= rem - total_width'(rd_cnt);
                    ret_state <= st_sp;
                    state     <= st_tx_start;
                end
                st_sp: begin
                    tx_data   <= ascii_space;
                    // nothing left to list, so this space ends the report
                    ret_state <= (rem == 0) ? st_finish : st_next;
                    state     <= st_tx_start;
                end
                st_next: begin
                    if (rd_col < max_size) begin
                        rd_col <= rd_col + 3'd1;
                        state  <= st_chk;
                    end else if (rd_row < max_size) begin
                        rd_row <= rd_row + 3'd1;
                        rd_col <= coord_width'(1);
                        state  <= st_chk;
                    end else begin
                        busy  <= 1'b0;  // grid exhausted
                        state <= st_idle;
                    end
                end

                // ========================================
                // uart send subroutine
                // ========================================
                st_tx_start: begin
                    tx_start <= 1'b1;
                    state    <= st_tx_hi;
                end
                st_tx_hi: begin
                    if (tx_busy) begin
                        state <= st_tx_lo;
                    end
                end
                st_tx_lo: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b0;
                        state    <= st_tx_rec;
                    end
                end
                st_tx_rec: begin
                    if (ret_state == st_finish) begin
                        busy  <= 1'b0;
                        state <= st_idle;
                    end else begin
                        state <= ret_state;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start && $past(tx_start) |-> tx_data == $past(tx_data));

    a_start_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> busy);

endmodule

/* common/census_pkg.sv */
package census_pkg;

    // ========================================
    // size grid
    // ========================================
    localparam int max_size       = 5;   // largest row or column count
    localparam int cell_count     = 25;  // max_size * max_size
    localparam int cell_idx_width = 5;   // flat cache index

    // ========================================
    // datapath widths
    // ========================================
    localparam int coord_width = 3;  // holds 1..5
    localparam int cnt_width   = 5;  // one per-size count
    localparam int total_width = 8;  // sum over all sizes

    // ========================================
    // report characters
    // ========================================
    localparam logic [7:0] ascii_zero  = 8'h30;  // digit 0
    localparam logic [7:0] ascii_space = 8'h20;  // separator between fields
    localparam logic [7:0] ascii_star  = 8'h2a;  // between row, col and count

endpackage

/* logic/count_cache.sv */
`timescale 1ns/1ps

module count_cache import census_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic [coord_width-1:0] wr_row,
    input  logic [coord_width-1:0] wr_col,
    input  logic [cnt_width-1:0]   wr_cnt,
    input  logic [coord_width-1:0] rd_row,
    input  logic [coord_width-1:0] rd_col,
    output logic [cnt_width-1:0]   rd_cnt
);

    logic [cnt_width-1:0]      mem [cell_count];
    logic [cell_idx_width-1:0] wr_idx;
    logic [cell_idx_width-1:0] rd_idx;

    // one-based row/col to row-major flat index
    function automatic logic [cell_idx_width-1:0] flat_idx(
        input logic [coord_width-1:0] row,
        input logic [coord_width-1:0] col
    );
        int idx;
        idx = (int'(row) - 1) * max_size + (int'(col) - 1);
        return cell_idx_width'(idx);
    endfunction

    assign wr_idx = flat_idx(wr_row, wr_col);
    assign rd_idx = flat_idx(rd_row, rd_col);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_cnt;
        end
    end

    assign rd_cnt = mem[rd_idx];  // zero-latency read

    // scanner must never address outside the grid
    a_wr_coord: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_row >= 1 && wr_row <= max_size && wr_col >= 1 && wr_col <= max_size);

endmodule

/* tests/tb_census.sv */
`timescale 1ns/1ps

module tb_census;

    localparam int grid       = 5;
    localparam int cells      = 25;
    // 4 reports x 153 bytes x 12 cycles + 4 x 80 scan cycles, rounded up
    localparam int max_cycles = 8000;
    localparam logic [31:0] seed = 32'd56;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start_req;
    logic       tx_busy;
    logic [4:0] qry_cnt;
    logic       busy;
    logic       tx_start;
    logic [7:0] tx_data;
    logic [2:0] qry_row;
    logic [2:0] qry_col;

    logic [4:0]  cnt_table [cells];  // storage model, row-major
    logic [7:0]  exp_bytes [$];
    int          exp_len;
    int          sent_count;
    int          busy_rises;
    int          cycle_count = 0;
    logic        busy_q;
    bit          started = 1'b0;
    logic [31:0] stim_rng = seed;
    logic [31:0] tx_rng = ~seed;  // separate stream for the uart model

    matrix_census_report DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_req (start_req),
        .tx_busy   (tx_busy),
        .qry_cnt   (qry_cnt),
        .busy      (busy),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .qry_row   (qry_row),
        .qry_col   (qry_col)
    );

    always #2 clk = ~clk;

    // ========================================
    // failure reporting and helpers
    // ========================================
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        report_failure($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic clear_table();
        int i;
        for (i = 0; i < cells; i++) begin
            cnt_table[i] = '0;
        end
    endtask

    task automatic set_cell(input int row, input int col, input int cnt);
        cnt_table[(row - 1) * grid + (col - 1)] = 5'(cnt);
    endtask

    task automatic fill_random();
        int i;
        int sum;
        int v;
        sum = 0;
        for (i = 0; i < cells; i++) begin
            stim_rng = xorshift32(stim_rng);
            v = int'(stim_rng % 32'd10);
            if (sum + v > 99) begin
                v = 99 - sum;  // total stays two digits
            end
            cnt_table[i] = 5'(v);
            sum += v;
        end
    endtask

    // total digits and space, then row*col*count for every nonzero size
    task automatic build_expected();
        int i;
        int r;
        int c;
        int sum;
        sum = 0;
        exp_bytes.delete();
        for (i = 0; i < cells; i++) begin
            sum += int'(cnt_table[i]);
        end
        if (sum >= 10) begin
            exp_bytes.push_back(8'h30 + 8'(sum / 10));
        end
        exp_bytes.push_back(8'h30 + 8'(sum % 10));
        exp_bytes.push_back(8'h20);
        for (r = 1; r <= grid; r++) begin
            for (c = 1; c <= grid; c++) begin
                i = (r - 1) * grid + (c - 1);
                if (cnt_table[i] != 0) begin
                    exp_bytes.push_back(8'h30 + 8'(r));
                    exp_bytes.push_back(8'h2a);
                    exp_bytes.push_back(8'h30 + 8'(c));
                    exp_bytes.push_back(8'h2a);
                    exp_bytes.push_back(8'h30 + 8'(cnt_table[i]));
                    exp_bytes.push_back(8'h20);
                end
            end
        end
        exp_len = exp_bytes.size();
    endtask

    // ========================================
    // storage and uart models
    // ========================================
    always_comb begin
        if (qry_row >= 1 && qry_row <= 5 && qry_col >= 1 && qry_col <= 5) begin
            qry_cnt = cnt_table[(int'(qry_row) - 1) * grid + int'(qry_col) - 1];
        end else begin
            qry_cnt = '0;
        end
    end

    task automatic check_tx_held(input logic [7:0] held);
        assert (tx_start) else report_failure("tx_start dropped before tx_busy fell");
        assert (tx_data == held) else report_mismatch("tx_data", tx_data, held);
    endtask

    initial begin : uart_model
        int         gap;
        int         hold;
        logic [7:0] held;
        tx_busy = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_start) begin
                held   = tx_data;
                tx_rng = xorshift32(tx_rng);
                gap    = 1 + int'(tx_rng % 32'd3);
                repeat (gap) begin
                    @(negedge clk);
                    check_tx_held(held);
                end
                tx_busy = 1'b1;  // byte taken here
                assert (sent_count < exp_len)
                    else report_failure("UART received more bytes than the report holds");
                assert (held == exp_bytes[sent_count])
                    else report_mismatch("tx_data", held, exp_bytes[sent_count]);
                sent_count++;
                tx_rng = xorshift32(tx_rng);
                hold   = 2 + int'(tx_rng % 32'd5);
                repeat (hold) begin
                    @(negedge clk);
                    check_tx_held(held);
                end
                tx_busy = 1'b0;
                @(negedge clk);
                assert (!tx_start) else report_failure("tx_start still high after tx_busy fell");
            end
        end
    end

    // ========================================
    // monitors
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            busy_rises <= 0;
        end else begin
            busy_q <= busy;
            if (busy && !busy_q) begin
                busy_rises <= busy_rises + 1;  // one per accepted start
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            report_failure($sformatf("timeout: run not finished after %0d cycles", max_cycles));
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !busy && !tx_start)
        else report_failure("busy or tx_start active before the first start");

    a_qry_row: assert property (@(posedge clk) disable iff (!rst_n)
        qry_row >= 1 && qry_row <= 5)
        else report_failure($sformatf("ERR qry_row: 0x%0h outside 0x1..0x5", qry_row));

    a_qry_col: assert property (@(posedge clk) disable iff (!rst_n)
        qry_col >= 1 && qry_col <= 5)
        else report_failure($sformatf("ERR qry_col: 0x%0h outside 0x1..0x5", qry_col));

    a_start_gap: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(tx_start) |=> !tx_start)
        else report_failure("tx_start rose again without a low cycle");

    // ========================================
    // stimulus
    // ========================================
    task automatic run_report(input int run_no, input bit extra_starts);
        build_expected();
        sent_count = 0;
        @(negedge clk);
        start_req = 1'b1;
        started   = 1'b1;
        @(negedge clk);
        start_req = 1'b0;
        if (extra_starts) begin
            // pulses through the scan and the whole report
            while (busy) begin
                repeat (37) @(negedge clk);
                if (busy) begin  // should be ignored
                    start_req = 1'b1;
                    @(negedge clk);
                    start_req = 1'b0;
                end
            end
        end
        while (busy) begin
            @(negedge clk);
        end
        assert (sent_count == exp_len) else report_mismatch("byte count", sent_count, exp_len);
        assert (busy_rises == run_no) else report_mismatch("busy rises", busy_rises, run_no);
        repeat (20) @(negedge clk);
        assert (!busy) else report_failure("a second report started without a start");
    endtask

    initial begin
        rst_n     = 1'b0;
        start_req = 1'b0;
        clear_table();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (10) @(negedge clk);  // idle window after reset

        run_report(1, 1'b0);  // empty table

        set_cell(1, 2, 3);
        set_cell(3, 3, 1);
        set_cell(5, 5, 4);
        run_report(2, 1'b0);  // total 8

        clear_table();
        set_cell(1, 1, 9);
        set_cell(2, 4, 7);
        set_cell(4, 1, 5);
        set_cell(5, 3, 2);
        run_report(3, 1'b0);  // total 23

        fill_random();
        run_report(4, 1'b1);

        $display("Done: no errors");
        $finish;
    end

endmodule

/* verilog.f */
common/census_pkg.sv
census/census_scan.sv
logic/count_cache.sv
census/report_writer.sv
census/matrix_census_report.sv
tests/tb_census.sv
